// ==== sim.f ====
+incdir+.
edge_pkg.sv
write_heap_ctrl.sv
write_heap_mem.sv
byte_range_mask.sv
write_packer.sv
req_edge.sv
tb_req_edge.sv

// ==== Makefile ====
# Verilator build and run of the request edge testbench

VERILATOR ?= verilator
TOP ?= tb_req_edge
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_req_edge.sv ====
`timescale 1ns/100ps
`include "edge_settings.svh"

module tb_req_edge
    import edge_pkg::*;
();

    localparam int TIMEOUT = 50;
    // Held entries above this count leave less than the slack free
    localparam int ALM_LEVEL = `EDGE_HEAP_ENTRIES - `EDGE_ALM_FULL_SLACK;

    logic clk;
    logic reset;
    logic afu_reset;
    wr_beat_t wr_beat;
    logic wr_alm_full;
    out_req_t out_req;
    heap_tag_t rd_tag;
    beat_num_t rd_beat;
    line_data_t rd_data;
    logic free;
    heap_tag_t free_tag;

    // One packet waiting in the heap, as the consumer remembers it
    typedef struct packed {
        heap_tag_t tag;
        logic [2:0] nbeats;
        line_data_t [`EDGE_MAX_BEATS-1:0] data;
    } held_pkt_t;

    held_pkt_t held_q[$];
    int held_cnt;
    logic [`EDGE_HEAP_ENTRIES-1:0] tag_held;
    logic [31:0] exp_addr;
    cl_len_t exp_len;
    logic exp_partial;
    byte_mask_t exp_mask;
    logic last_sent;
    logic last_sent_q;
    logic rd_check;
    logic rd_check_q;
    line_data_t rd_exp;
    line_data_t rd_exp_q;
    logic reset_q;
    int cyc;
    int err_cnt;
    int test_cnt;
    int fail_cnt;
    int test_base;
    string test_name;

    req_edge DUT (
        .clk(clk),
        .reset(reset),
        .afu_reset(afu_reset),
        .wr_beat(wr_beat),
        .wr_alm_full(wr_alm_full),
        .out_req(out_req),
        .rd_tag(rd_tag),
        .rd_beat(rd_beat),
        .rd_data(rd_data),
        .free(free),
        .free_tag(free_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Copies one cycle late, so each check lines up with the DUT's register stage
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        reset_q <= reset;
        last_sent_q <= last_sent;
        rd_check_q <= rd_check;
        rd_exp_q <= rd_exp;
    end

    task automatic report_value(input string what, input logic [127:0] exp,
                                input logic [127:0] act);
        err_cnt++;
        $display("ERROR %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_fault(input string msg);
        err_cnt++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    // ==============================
    // Checks
    // ==============================

    a_afu_reset: assert property (@(posedge clk) (cyc >= 2) |-> (afu_reset == reset_q))
        else report_value("afu_reset", 128'($sampled(reset_q)), 128'($sampled(afu_reset)));

    // Level high and no request while reset is held
    a_reset_out: assert property (@(posedge clk) (cyc >= 2 && reset && reset_q) |->
        (wr_alm_full && !out_req.valid))
        else report_value("alm_full and valid", 128'(2'b10),
            128'({$sampled(wr_alm_full), $sampled(out_req.valid)}));

    // One request exactly one cycle after each last beat, and none otherwise
    a_req_once: assert property (@(posedge clk) disable iff (reset)
        out_req.valid == last_sent_q)
        else report_value("request valid", 128'($sampled(last_sent_q)),
            128'($sampled(out_req.valid)));

    a_req_hdr: assert property (@(posedge clk) disable iff (reset)
        out_req.valid |-> ({out_req.address, out_req.cl_len} == {exp_addr, exp_len}))
        else report_value("address and length", 128'({exp_addr, exp_len}),
            128'($sampled({out_req.address, out_req.cl_len})));

    a_req_mask: assert property (@(posedge clk) disable iff (reset)
        out_req.valid |-> ({out_req.is_partial, out_req.mask} == {exp_partial, exp_mask}))
        else report_value("partial and mask", 128'({exp_partial, exp_mask}),
            128'($sampled({out_req.is_partial, out_req.mask})));

    a_req_tag: assert property (@(posedge clk) disable iff (reset)
        out_req.valid |-> ((out_req.payload.tag_view.pad == '0) &&
        !tag_held[out_req.payload.tag_view.tag]))
        else report_fault("request tag is already outstanding or its payload is not clean");

    a_rd_data: assert property (@(posedge clk) disable iff (reset)
        rd_check_q |-> (rd_data == rd_exp_q))
        else report_value("read data", $sampled(rd_exp_q), $sampled(rd_data));

    // Ones from the start byte for len bytes, or up to the top byte when len is zero
    function automatic byte_mask_t expected_range_mask(input byte_idx_t start,
                                                      input byte_idx_t len);
        byte_mask_t m;
        int count;
        m = '0;
        count = (len == '0) ? `EDGE_LINE_BYTES - int'(start) : int'(len);
        for (int k = 0; k < count; k++)
            m[int'(start) + k] = 1'b1;
        return m;
    endfunction

    // ==============================
    // Requester and consumer
    // ==============================

    task automatic drive_beat(input logic sop, input logic [31:0] addr, input cl_len_t len,
                              input logic byte_mode, input byte_idx_t bstart,
                              input byte_idx_t blen, input line_data_t data,
                              input logic last);
        wr_beat_t b;
        b.valid = 1'b1;
        b.hdr.address = addr;
        b.hdr.cl_len = len;
        b.hdr.sop = sop;
        b.hdr.byte_mode = byte_mode;
        b.hdr.byte_start = bstart;
        b.hdr.byte_len = blen;
        b.payload.data = data;
        wr_beat <= b;
        last_sent <= last;
        @(posedge clk);
    endtask

    task automatic wait_alm_low();
        int n;
        n = 0;
        while (wr_alm_full && n < TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (wr_alm_full)
            report_fault("wr_alm_full stayed high, so no packet could start");
    endtask

    // Sends one packet, waits for its request and keeps the packet as held
    task automatic send_packet(input int n, input logic byte_mode);
        logic [31:0] addr;
        cl_len_t len;
        byte_idx_t bstart;
        byte_idx_t blen;
        held_pkt_t pkt;
        int w;
        len = cl_len_t'(n - 1);
        addr = $urandom;
        addr[1:0] = addr[1:0] & ~len;
        bstart = '0;
        blen = '0;
        if (byte_mode)
        begin
            bstart = byte_idx_t'($urandom_range(`EDGE_LINE_BYTES - 1, 0));
            // Sixteen wraps to zero, which also means up to the top byte
            blen = byte_idx_t'($urandom_range(`EDGE_LINE_BYTES - int'(bstart), 0));
        end
        exp_addr = addr;
        exp_len = len;
        exp_partial = byte_mode;
        exp_mask = byte_mode ? expected_range_mask(bstart, blen) : '1;
        pkt = '0;
        pkt.nbeats = 3'(n);
        wait_alm_low();
        for (int i = 0; i < n; i++)
        begin
            pkt.data[i] = {$urandom, $urandom, $urandom, $urandom};
            if (i == 0)
                drive_beat(1'b1, addr, len, byte_mode, bstart, blen, pkt.data[i], n == 1);
            else
                // Junk header fields that the edge must ignore
                drive_beat(1'b0, $urandom, len, 1'($urandom), byte_idx_t'($urandom),
                           byte_idx_t'($urandom), pkt.data[i], i == n - 1);
        end
        wr_beat <= '0;
        last_sent <= 1'b0;
        w = 0;
        while (!out_req.valid && w < TIMEOUT)
        begin
            @(posedge clk);
            w++;
        end
        if (out_req.valid)
        begin
            pkt.tag = out_req.payload.tag_view.tag;
            tag_held[pkt.tag] <= 1'b1;
            held_q.push_back(pkt);
            held_cnt++;
        end
        else
            report_fault("no request came after the last beat");
    endtask

    // Reads every beat of each held packet in order, then frees its tag
    task automatic drain_heap();
        held_pkt_t pkt;
        while (held_q.size() > 0)
        begin
            pkt = held_q.pop_front();
            for (int b = 0; b < int'(pkt.nbeats); b++)
            begin
                rd_tag <= pkt.tag;
                rd_beat <= beat_num_t'(b);
                rd_check <= 1'b1;
                rd_exp <= pkt.data[b];
                @(posedge clk);
            end
            rd_check <= 1'b0;
            free <= 1'b1;
            free_tag <= pkt.tag;
            tag_held[pkt.tag] <= 1'b0;
            @(posedge clk);
            free <= 1'b0;
            held_cnt--;
        end
    endtask

    // The level settles two cycles after a free reaches the heap
    task automatic check_alm_full();
        logic exp;
        repeat (2) @(posedge clk);
        exp = (held_cnt > ALM_LEVEL);
        assert (wr_alm_full == exp)
        else report_value("wr_alm_full", 128'(exp), 128'(wr_alm_full));
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_base = err_cnt;
    endtask

    task automatic end_test();
        repeat (2) @(posedge clk);
        test_cnt++;
        if (err_cnt == test_base)
            $display("test %s: ok", test_name);
        else
        begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", test_name, err_cnt - test_base);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        void'($urandom(32'hde0d));
        reset = 1'b1;
        wr_beat = '0;
        rd_tag = '0;
        rd_beat = '0;
        free = 1'b0;
        free_tag = '0;
        last_sent = 1'b0;
        rd_check = 1'b0;
        rd_exp = '0;
        tag_held = '0;
        held_cnt = 0;
        cyc = 0;
        err_cnt = 0;
        test_cnt = 0;
        fail_cnt = 0;
        begin_test("reset");
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_alm_full();
        end_test();
        begin_test("single beat");
        repeat (4)
        begin
            send_packet(1, 1'b0);
            drain_heap();
        end
        end_test();
        begin_test("multi beat");
        repeat (8)
        begin
            send_packet($urandom_range(1, 0) ? 4 : 2, 1'b0);
            drain_heap();
        end
        end_test();
        begin_test("byte range");
        repeat (10)
        begin
            send_packet(1, 1'b1);
            drain_heap();
        end
        end_test();
        // Hold packets until the level has to rise, then release them all
        begin_test("heap level");
        repeat (ALM_LEVEL + 1)
        begin
            send_packet(1 << $urandom_range(2, 0), 1'b0);
            check_alm_full();
        end
        drain_heap();
        check_alm_full();
        end_test();
        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== req_edge.sv ====
`timescale 1ns/100ps

module req_edge
    import edge_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic afu_reset,
    input  wr_beat_t wr_beat,
    output logic wr_alm_full,
    output out_req_t out_req,
    input  heap_tag_t rd_tag,
    input  beat_num_t rd_beat,
    output line_data_t rd_data,
    input  logic free,
    input  heap_tag_t free_tag
);

    logic alloc;
    heap_tag_t alloc_tag;
    logic heap_alm_full;
    logic heap_wen;
    heap_tag_t heap_wtag;
    beat_num_t heap_wbeat;
    byte_mask_t range_mask;

    // Requester leaves reset a cycle after the edge does
    always_ff @(posedge clk)
    begin
        afu_reset <= reset;
    end

    // Level to the requester is held high through reset
    always_ff @(posedge clk)
    begin
        if (reset)
            wr_alm_full <= 1'b1;
        else
            wr_alm_full <= heap_alm_full;
    end

    write_heap_ctrl u_heap_ctrl (
        .clk(clk),
        .reset(reset),
        .alloc(alloc),
        .alloc_tag(alloc_tag),
        .free(free),
        .free_tag(free_tag),
        .alm_full(heap_alm_full)
    );

    write_heap_mem u_heap_mem (
        .clk(clk),
        .wen(heap_wen),
        .wtag(heap_wtag),
        .wbeat(heap_wbeat),
        .wdata(wr_beat.payload.data),
        .rd_tag(rd_tag),
        .rd_beat(rd_beat),
        .rd_data(rd_data)
    );

    byte_range_mask u_range_mask (
        .clk(clk),
        .byte_start(wr_beat.hdr.byte_start),
        .byte_len(wr_beat.hdr.byte_len),
        .mask(range_mask)
    );

    write_packer u_packer (
        .clk(clk),
        .reset(reset),
        .wr_beat(wr_beat),
        .alloc_tag(alloc_tag),
        .alloc(alloc),
        .heap_wen(heap_wen),
        .heap_wtag(heap_wtag),
        .heap_wbeat(heap_wbeat),
        .range_mask(range_mask),
        .out_req(out_req)
    );

endmodule

// ==== write_packer.sv ====
`timescale 1ns/100ps

module write_packer
    import edge_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  wr_beat_t wr_beat,
    input  heap_tag_t alloc_tag,
    output logic alloc,
    output logic heap_wen,
    output heap_tag_t heap_wtag,
    output beat_num_t heap_wbeat,
    input  byte_mask_t range_mask,
    output out_req_t out_req
);

    // ==============================
    // Packet tracking
    // ==============================

    logic packet_active;
    // Number of the next beat expected in an open packet
    beat_num_t beat_cnt;

    // Values saved from the start beat, since later beats may carry junk
    logic [31:0] sop_addr;
    cl_len_t sop_len;
    logic sop_byte_mode;
    heap_tag_t sop_tag;

    logic is_sop;
    logic [31:0] cur_addr;
    cl_len_t cur_len;
    logic cur_byte_mode;
    heap_tag_t cur_tag;
    beat_num_t cur_beat;
    logic is_eop;

    // Canonical header, taken live on the start beat and from the saved copy after
    always_comb
    begin
        is_sop = wr_beat.valid && wr_beat.hdr.sop;
        cur_addr = is_sop ? wr_beat.hdr.address : sop_addr;
        cur_len = is_sop ? wr_beat.hdr.cl_len : sop_len;
        cur_byte_mode = is_sop ? wr_beat.hdr.byte_mode : sop_byte_mode;
        cur_tag = is_sop ? alloc_tag : sop_tag;
        cur_beat = is_sop ? '0 : beat_cnt;
        // Length code equals the number of the last beat
        is_eop = wr_beat.valid && (cur_beat == beat_num_t'(cur_len));
    end

    // Claim a heap entry on the start beat and store every beat under it
    assign alloc = is_sop;
    assign heap_wen = wr_beat.valid;
    assign heap_wtag = cur_tag;
    assign heap_wbeat = cur_beat;

    always_ff @(posedge clk)
    begin
        if (is_sop)
        begin
            sop_addr <= wr_beat.hdr.address;
            sop_len <= wr_beat.hdr.cl_len;
            sop_byte_mode <= wr_beat.hdr.byte_mode;
            sop_tag <= alloc_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            packet_active <= 1'b0;
            beat_cnt <= '0;
        end
        else if (wr_beat.valid)
        begin
            packet_active <= !is_eop;
            beat_cnt <= is_eop ? '0 : cur_beat + beat_num_t'(1);
        end
    end

    // ==============================
    // Outbound request
    // ==============================

    logic req_valid_q;
    logic [31:0] req_addr_q;
    cl_len_t req_len_q;
    logic req_partial_q;
    heap_tag_t req_tag_q;

    // Only the last beat sends a request, so data is all in the heap by then
    always_ff @(posedge clk)
    begin
        req_addr_q <= cur_addr;
        req_len_q <= cur_len;
        req_partial_q <= cur_byte_mode && (cur_len == CL_LEN_1);
        req_tag_q <= cur_tag;
        if (reset)
            req_valid_q <= 1'b0;
        else
            req_valid_q <= is_eop;
    end

    // The range mask lands in the same cycle as the registered request
    always_comb
    begin
        out_req.valid = req_valid_q;
        out_req.address = req_addr_q;
        out_req.cl_len = req_len_q;
        out_req.is_partial = req_partial_q;
        out_req.mask = req_partial_q ? range_mask : '1;
        out_req.payload.tag_view.pad = '0;
        out_req.payload.tag_view.tag = req_tag_q;
    end

    // ==============================
    // Requester format checks
    // ==============================

    // A start beat opens a packet and any other beat continues one
    a_sop_order: assert property (@(posedge clk) disable iff (reset)
        wr_beat.valid |-> (wr_beat.hdr.sop != packet_active));

    a_len_steady: assert property (@(posedge clk) disable iff (reset)
        (wr_beat.valid && !wr_beat.hdr.sop) |-> (wr_beat.hdr.cl_len == sop_len));

    a_addr_align: assert property (@(posedge clk) disable iff (reset)
        is_sop |-> ((wr_beat.hdr.address[1:0] & wr_beat.hdr.cl_len) == 2'b00));

    a_byte_single: assert property (@(posedge clk) disable iff (reset)
        (is_sop && wr_beat.hdr.byte_mode) |-> (wr_beat.hdr.cl_len == CL_LEN_1));

endmodule

// ==== byte_range_mask.sv ====
`timescale 1ns/100ps
`include "edge_settings.svh"

module byte_range_mask
    import edge_pkg::*;
(
    input  logic clk,
    input  byte_idx_t byte_start,
    input  byte_idx_t byte_len,
    output byte_mask_t mask
);

    byte_idx_t start_idx;
    // End index is one past the last byte of the range
    byte_idx_t end_idx;

    // Both indices follow the requester every cycle and the packer picks the mask
    // only for a byte-mode request
    // A length of zero maps to an end of zero, which decodes as end of line
    always_ff @(posedge clk)
    begin
        start_idx <= byte_start;
        end_idx <= (byte_len == '0) ? '0 : byte_start + byte_len;
    end

    // Bytes at or above the start, and strictly below the end
    always_comb
    begin
        for (int i = 0; i < `EDGE_LINE_BYTES; i++)
        begin
            mask[i] = (i >= int'(start_idx)) &&
                      ((end_idx == '0) || (i < int'(end_idx)));
        end
    end

endmodule

// ==== write_heap_mem.sv ====
`timescale 1ns/100ps
`include "edge_settings.svh"

module write_heap_mem
    import edge_pkg::*;
(
    input  logic clk,
    input  logic wen,
    input  heap_tag_t wtag,
    input  beat_num_t wbeat,
    input  line_data_t wdata,
    input  heap_tag_t rd_tag,
    input  beat_num_t rd_beat,
    output line_data_t rd_data
);

    localparam int DEPTH = `EDGE_HEAP_ENTRIES * `EDGE_MAX_BEATS;

    // Each entry owns a block of lines, one per beat of its packet
    line_data_t mem [DEPTH];

    // Beats are stored as they arrive, in the same cycle
    always_ff @(posedge clk)
    begin
        if (wen)
            mem[{wtag, wbeat}] <= wdata;
    end

    // Read port with a single cycle of latency
    always_ff @(posedge clk)
    begin
        rd_data <= mem[{rd_tag, rd_beat}];
    end

endmodule

// ==== write_heap_ctrl.sv ====
`timescale 1ns/100ps
`include "edge_settings.svh"

module write_heap_ctrl
    import edge_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic alloc,
    output heap_tag_t alloc_tag,
    input  logic free,
    input  heap_tag_t free_tag,
    output logic alm_full
);

    localparam int CNT_W = $clog2(`EDGE_HEAP_ENTRIES + 1);

    // One bit per entry, set while the entry is free
    logic [`EDGE_HEAP_ENTRIES-1:0] free_map;
    logic [CNT_W-1:0] free_cnt;

    // Offer the lowest free entry, scanning down so the last hit wins
    always_comb
    begin
        alloc_tag = '0;
        for (int i = `EDGE_HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (free_map[i])
            begin
                alloc_tag = heap_tag_t'(i);
            end
        end
    end

    // Allocation and release can land in the same cycle on different entries
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_map <= '1;
            free_cnt <= CNT_W'(`EDGE_HEAP_ENTRIES);
        end
        else
        begin
            if (alloc)
                free_map[alloc_tag] <= 1'b0;
            if (free)
                free_map[free_tag] <= 1'b1;
            free_cnt <= free_cnt + CNT_W'(free) - CNT_W'(alloc);
        end
    end

    // Level is raw here and gets registered at the top before the requester
    assign alm_full = (free_cnt < CNT_W'(`EDGE_ALM_FULL_SLACK));

    // The consumer may only release an entry the packer has claimed
    a_free_held: assert property (@(posedge clk) disable iff (reset)
        free |-> !free_map[free_tag]);

    // The slack must keep a start beat from arriving with the heap empty
    a_alloc_room: assert property (@(posedge clk) disable iff (reset)
        alloc |-> (free_cnt != '0));

endmodule

// ==== edge_pkg.sv ====
package edge_pkg;

    `include "edge_settings.svh"

    // ==============================
    // Widths derived from the settings
    // ==============================

    localparam int LINE_BITS = `EDGE_LINE_BYTES * 8;
    localparam int TAG_BITS = $clog2(`EDGE_HEAP_ENTRIES);

    // Basic words of a line and of its addressing
    typedef logic [LINE_BITS-1:0] line_data_t;
    typedef logic [`EDGE_LINE_BYTES-1:0] byte_mask_t;
    typedef logic [$clog2(`EDGE_LINE_BYTES)-1:0] byte_idx_t;
    typedef logic [TAG_BITS-1:0] heap_tag_t;
    typedef logic [$clog2(`EDGE_MAX_BEATS)-1:0] beat_num_t;

    // Length code is beats minus one, so codes 0, 1 and 3 are legal
    typedef logic [1:0] cl_len_t;

    // Code of a single-beat packet
    localparam cl_len_t CL_LEN_1 = 2'd0;

    // Tag view of a line word, heap tag in the low bits and zero above
    typedef struct packed {
        logic [LINE_BITS-TAG_BITS-1:0] pad;
        heap_tag_t tag;
    } line_tag_view_t;

    // One line word, read as data on the way in and as a tag on the way out
    typedef union packed {
        line_data_t data;
        line_tag_view_t tag_view;
    } line_payload_u;

    // Write header as the requester presents it on every beat
    typedef struct packed {
        logic [31:0] address;
        cl_len_t cl_len;
        logic sop;
        logic byte_mode;
        byte_idx_t byte_start;
        // Zero means the range runs to the end of the line
        byte_idx_t byte_len;
    } wr_hdr_t;

    // One beat from the requester
    typedef struct packed {
        logic valid;
        wr_hdr_t hdr;
        line_payload_u payload;
    } wr_beat_t;

    // One control request per packet toward the pipeline
    typedef struct packed {
        logic valid;
        logic [31:0] address;
        cl_len_t cl_len;
        logic is_partial;
        byte_mask_t mask;
        line_payload_u payload;
    } out_req_t;

endpackage

// ==== edge_settings.svh ====
`ifndef EDGE_SETTINGS_SVH
`define EDGE_SETTINGS_SVH

// ==============================
// Line geometry
// ==============================

// Bytes in one line of write data
`define EDGE_LINE_BYTES 16

// ==============================
// Write heap sizing
// ==============================

// Packet entries in the write heap, each one holding a whole packet
`define EDGE_HEAP_ENTRIES 8

// Largest packet in beats, which sets the lines held per heap entry
`define EDGE_MAX_BEATS 4

// Almost-full rises while fewer entries than this are free
// Two entries cover the start beats that can still arrive while the
// registered level to the requester catches up
`define EDGE_ALM_FULL_SLACK 2

`endif
